//--- Bender.yml
package:
  name: dma_fe

sources:
  - include_dirs:
      - include
    files:
      - src/dma_fe_pkg.sv
      - src/dma_fe_decode.sv
      - src/dma_fe_job_fifo.sv
      - src/dma_fe_nd_expand.sv
      - src/dma_fe_id_gen.sv
      - src/dma_fe_rsp_spill.sv
      - src/dma_fe_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/dma_fe_assertions.sv
      - dv/dma_fe_tb.sv

//--- dma_fe_top.f
+incdir+include
src/dma_fe_pkg.sv
src/dma_fe_decode.sv
src/dma_fe_job_fifo.sv
src/dma_fe_nd_expand.sv
src/dma_fe_id_gen.sv
src/dma_fe_rsp_spill.sv
src/dma_fe_top.sv
dv/dma_fe_assertions.sv
dv/dma_fe_tb.sv

//--- dv/dma_fe_assertions.sv
// -----------------------------------------------
// burst port protocol checks
// bound into the nd expander
// -----------------------------------------------

module dma_fe_assertions (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input dma_fe_pkg::burst_req_t burst_req_o,
    input logic                   burst_req_valid_o,
    input logic                   burst_req_ready_i,
    input logic                   retire_o,
    input logic                   busy_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // request held with stable payload until taken
    burst_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        burst_req_valid_o && !burst_req_ready_i |=> burst_req_valid_o && $stable(burst_req_o))
        else $error("burst request dropped or changed before it was accepted");

    retire_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        retire_o |=> !retire_o)
        else $error("retire held high for more than one cycle");

    // expander leaves reset idle
    reset_idle_a: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !burst_req_valid_o && !busy_o)
        else $error("burst valid or busy high right after reset");

endmodule

//--- dv/dma_fe_tb.sv
// -----------------------------------------------
// dma frontend testbench
// table driven instruction stimulus, random burst
// responder and in-order response checking
// -----------------------------------------------

`include "dma_fe_consts.svh"

module dma_fe_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import dma_fe_pkg::*;

    localparam int ReqTimeout   = 200;
    localparam int DrainTimeout = 500;

    typedef enum logic [2:0] {
        ST_REQ,
        ST_BLOCK,
        ST_BSTALL,
        ST_RSTALL,
        ST_DRAIN
    } step_kind_e;

    typedef struct packed {
        step_kind_e                kind;
        dma_op_e                   op;
        logic [`DMA_FE_ADDR_W-1:0] arga;
        logic [`DMA_FE_ADDR_W-1:0] argb;
        logic [`DMA_FE_ID_W-1:0]   exp;
    } step_t;

    logic       clk_i;
    logic       rst_n_i;
    acc_req_t   acc_req_i;
    logic       acc_req_valid_i;
    logic       acc_req_ready_o;
    acc_rsp_t   acc_rsp_o;
    logic       acc_rsp_valid_o;
    logic       acc_rsp_ready_i;
    burst_req_t burst_req_o;
    logic       burst_req_valid_o;
    logic       burst_req_ready_i;
    logic       burst_done_i;
    logic       busy_o;

    step_t                   steps[$];
    acc_rsp_t                exp_rsps[$];
    burst_req_t              exp_bursts[$];
    int                      due_q[$];
    nd_job_t                 model_job;
    logic [31:0]             lfsr;
    logic [`DMA_FE_TAG_W-1:0] tag_cnt;
    logic                    burst_stall;
    int                      rsp_release;
    int                      cyc;
    int                      last_due;

    dma_fe_top dut0 (.*);

    bind dma_fe_nd_expand dma_fe_assertions i_expand_sva (
        .clk_i             ( clk_i             ),
        .rst_n_i           ( rst_n_i           ),
        .burst_req_o       ( burst_req_o       ),
        .burst_req_valid_o ( burst_req_valid_o ),
        .burst_req_ready_i ( burst_req_ready_i ),
        .retire_o          ( retire_o          ),
        .busy_o            ( busy_o            )
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // -----------------------------------------------
    // helpers
    // -----------------------------------------------
    function automatic logic next_rand_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] got);
        stop_on_failure($sformatf("ERROR at %0t: %s expected %0h, got %0h",
                                  $time, sig, exp, got));
    endtask

    task automatic check_rsp(input acc_rsp_t exp, input acc_rsp_t got);
        if (got.tag !== exp.tag) begin
            report_mismatch("acc_rsp_o.tag", 32'(exp.tag), 32'(got.tag));
        end else if (got.data !== exp.data) begin
            report_mismatch("acc_rsp_o.data", exp.data, got.data);
        end
    endtask

    task automatic check_burst(input burst_req_t exp, input burst_req_t got);
        if (got.src !== exp.src) begin
            report_mismatch("burst_req_o.src", exp.src, got.src);
        end else if (got.dst !== exp.dst) begin
            report_mismatch("burst_req_o.dst", exp.dst, got.dst);
        end else if (got.len !== exp.len) begin
            report_mismatch("burst_req_o.len", exp.len, got.len);
        end
    endtask

    task automatic check_busy(input logic exp, input logic got);
        if (got !== exp) begin
            report_mismatch("busy_o", 32'(exp), 32'(got));
        end
    endtask

    task automatic add_step(input step_kind_e kind, input dma_op_e op,
                            input logic [31:0] arga, input logic [31:0] argb,
                            input logic [31:0] exp);
        step_t s;
        s.kind = kind;
        s.op   = op;
        s.arga = arga;
        s.argb = argb;
        s.exp  = exp;
        steps.push_back(s);
    endtask

    // staged job model, expected responses and row bursts
    task automatic update_model(input step_t s, input logic [`DMA_FE_TAG_W-1:0] tag);
        acc_rsp_t   rsp;
        burst_req_t b;
        int         reps;
        rsp.tag  = tag;
        rsp.data = s.exp;
        case (s.op)
            OP_SRC: model_job.burst.src = s.arga;
            OP_DST: model_job.burst.dst = s.arga;
            OP_STR: begin
                model_job.src_stride = s.arga;
                model_job.dst_stride = s.argb;
            end
            OP_REP: model_job.reps = s.arga;
            OP_CPY: begin
                exp_rsps.push_back(rsp);
                reps = (!s.argb[1] || model_job.reps == 0) ? 1 : int'(model_job.reps);
                for (int k = 0; k < reps; k++) begin
                    b.src = model_job.burst.src + k * model_job.src_stride;
                    b.dst = model_job.burst.dst + k * model_job.dst_stride;
                    b.len = s.arga;
                    exp_bursts.push_back(b);
                end
            end
            default: exp_rsps.push_back(rsp);
        endcase
    endtask

    task automatic send_req(input step_t s, input int block_cycles);
        logic accepted;
        int   waited;
        acc_req_i.tag   = tag_cnt;
        acc_req_i.op    = s.op;
        acc_req_i.arga  = s.arga;
        acc_req_i.argb  = s.argb;
        acc_req_valid_i = 1'b1;
        // held off while the queue is full
        for (int n = 0; n < block_cycles; n++) begin
            @(negedge clk_i);
            if (acc_req_ready_o) begin
                stop_on_failure("copy was accepted while the job queue was full");
            end
            // stalled bursts keep the frontend busy
            check_busy(1'b1, busy_o);
        end
        if (block_cycles > 0) begin
            burst_stall = 1'b0;
        end
        accepted = 1'b0;
        waited   = 0;
        while (!accepted && waited < ReqTimeout) begin
            @(negedge clk_i);
            accepted = acc_req_ready_o;
            waited++;
        end
        if (!accepted) begin
            stop_on_failure("request was not accepted before the timeout");
        end else begin
            @(posedge clk_i);
            #1;
            acc_req_valid_i = 1'b0;
            update_model(s, tag_cnt);
            tag_cnt++;
        end
    endtask

    task automatic wait_drain();
        logic idle;
        int   waited;
        idle   = 1'b0;
        waited = 0;
        while (!idle && waited < DrainTimeout) begin
            @(posedge clk_i);
            #1;
            idle = exp_bursts.size() == 0 && due_q.size() == 0 && !busy_o;
            waited++;
        end
        if (!idle) begin
            stop_on_failure("outstanding bursts did not finish before the timeout");
        end
    endtask

    // -----------------------------------------------
    // burst responder and output monitors
    // -----------------------------------------------
    always @(posedge clk_i) begin : respond
        logic hold;
        logic rsp_go;
        logic fire;
        cyc    = cyc + 1;
        hold   = burst_stall;
        rsp_go = (cyc >= rsp_release);
        fire   = (due_q.size() != 0) && (due_q[0] <= cyc);
        if (fire) begin
            void'(due_q.pop_front());
        end
        #1;
        burst_done_i      = fire;
        burst_req_ready_i = !hold && next_rand_bit();
        acc_rsp_ready_i   = rsp_go;
    end

    always @(negedge clk_i) begin : burst_monitor
        int due;
        if (rst_n_i && burst_req_valid_o && burst_req_ready_i) begin
            if (exp_bursts.size() == 0) begin
                stop_on_failure("burst request issued with no row outstanding");
            end else begin
                check_burst(exp_bursts.pop_front(), burst_req_o);
            end
            // done a few cycles later, one per cycle, in order
            due = cyc + 2 + int'({next_rand_bit(), next_rand_bit()});
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            due_q.push_back(due);
        end
    end

    always @(negedge clk_i) begin
        if (rst_n_i && acc_rsp_valid_o && acc_rsp_ready_i) begin
            if (exp_rsps.size() == 0) begin
                stop_on_failure("response arrived with no request outstanding");
            end else begin
                check_rsp(exp_rsps.pop_front(), acc_rsp_o);
            end
        end
    end

    // -----------------------------------------------
    // stimulus table
    // -----------------------------------------------
    initial begin
        int waited;
        acc_req_i         = '0;
        acc_req_valid_i   = 1'b0;
        acc_rsp_ready_i   = 1'b1;
        burst_req_ready_i = 1'b0;
        burst_done_i      = 1'b0;
        rst_n_i           = 1'b0;
        lfsr              = 32'ha812;
        tag_cnt           = '0;
        burst_stall       = 1'b0;
        rsp_release       = 0;
        cyc               = 0;
        last_due          = 0;
        model_job         = '0;

        // one-dimensional copies
        add_step(ST_REQ, OP_SRC, 32'h1000_0000, 0, 0);
        add_step(ST_REQ, OP_DST, 32'h2000_0000, 0, 0);
        add_step(ST_REQ, OP_CPY, 32'h40, 0, 1);
        add_step(ST_REQ, OP_SRC, 32'h1000_0100, 0, 0);
        add_step(ST_REQ, OP_CPY, 32'h80, 0, 2);
        // two-dimensional, three rows
        add_step(ST_REQ, OP_STR, 32'h200, 32'h400, 0);
        add_step(ST_REQ, OP_REP, 3, 0, 0);
        add_step(ST_REQ, OP_DST, 32'h3000_0000, 0, 0);
        add_step(ST_REQ, OP_CPY, 32'h20, 2, 3);
        add_step(ST_DRAIN, OP_SRC, 0, 0, 0);
        add_step(ST_REQ, OP_STAT, 0, STAT_COMPLETED, 3);
        add_step(ST_REQ, OP_STAT, 0, STAT_NEXT, 4);
        add_step(ST_REQ, OP_STAT, 0, STAT_BUSY, 0);
        // burst port stalled until the queue fills
        add_step(ST_BSTALL, OP_SRC, 0, 0, 0);
        add_step(ST_REQ, OP_CPY, 32'h10, 0, 4);
        add_step(ST_REQ, OP_STAT, 0, STAT_BUSY, 1);
        add_step(ST_REQ, OP_CPY, 32'h10, 0, 5);
        add_step(ST_REQ, OP_CPY, 32'h10, 0, 6);
        add_step(ST_REQ, OP_CPY, 32'h10, 0, 7);
        add_step(ST_REQ, OP_STAT, 0, STAT_FULL, 1);
        add_step(ST_BLOCK, OP_CPY, 32'h10, 0, 8);
        add_step(ST_DRAIN, OP_SRC, 0, 0, 0);
        // response channel stalled
        add_step(ST_RSTALL, OP_SRC, 0, 0, 0);
        add_step(ST_REQ, OP_STAT, 0, STAT_NEXT, 9);
        add_step(ST_REQ, OP_STAT, 0, STAT_COMPLETED, 8);
        add_step(ST_REQ, OP_STAT, 0, STAT_BUSY, 0);
        add_step(ST_REQ, OP_STAT, 0, STAT_FULL, 0);
        add_step(ST_REQ, OP_CPY, 32'h8, 2, 9);
        add_step(ST_DRAIN, OP_SRC, 0, 0, 0);
        // zero reps on a 2d copy gives one row
        add_step(ST_REQ, OP_REP, 0, 0, 0);
        add_step(ST_REQ, OP_CPY, 32'h4, 2, 10);
        add_step(ST_DRAIN, OP_SRC, 0, 0, 0);
        add_step(ST_REQ, OP_STAT, 0, STAT_COMPLETED, 10);
        add_step(ST_REQ, OP_STAT, 0, STAT_NEXT, 11);

        repeat (10) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        foreach (steps[i]) begin
            case (steps[i].kind)
                ST_BSTALL: burst_stall = 1'b1;
                ST_RSTALL: rsp_release = cyc + 12;
                ST_DRAIN:  wait_drain();
                ST_BLOCK:  send_req(steps[i], 20);
                default:   send_req(steps[i], 0);
            endcase
        end

        waited = 0;
        while (exp_rsps.size() != 0 && waited < ReqTimeout) begin
            @(posedge clk_i);
            waited++;
        end
        if (exp_rsps.size() == 0 && exp_bursts.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_on_failure("expected responses or bursts never arrived");
        end
    end

endmodule

//--- include/dma_fe_consts.svh
// -----------------------------------------------
// dma frontend constants
// widths of the accelerator port and transfer
// ids, depth of the job queue
// -----------------------------------------------

`ifndef DMA_FE_CONSTS_SVH
`define DMA_FE_CONSTS_SVH

// addresses, lengths, strides and repetitions
`define DMA_FE_ADDR_W 32

// transfer ids and response data
`define DMA_FE_ID_W 32

// request tag echoed back in each response
`define DMA_FE_TAG_W 5

// jobs held between decoder and expander
`define DMA_FE_FIFO_DEPTH 3

`endif

//--- src/dma_fe_decode.sv
// -----------------------------------------------
// dma instruction decoder
// stages job fields, pushes copies into the queue
// and composes copy and status responses
// -----------------------------------------------

`include "dma_fe_consts.svh"

module dma_fe_decode (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  dma_fe_pkg::acc_req_t    acc_req_i,
    input  logic                    acc_req_valid_i,
    output logic                    acc_req_ready_o,
    input  logic                    spill_ready_i,
    output dma_fe_pkg::acc_rsp_t    rsp_o,
    output logic                    rsp_valid_o,
    input  logic                    fifo_full_i,
    output logic                    push_o,
    output dma_fe_pkg::nd_job_t     job_o,
    input  logic [`DMA_FE_ID_W-1:0] next_id_i,
    input  logic [`DMA_FE_ID_W-1:0] completed_id_i,
    input  logic                    busy_i
);
    import dma_fe_pkg::*;

    nd_job_t   staged_q;
    nd_job_t   staged_d;
    stat_sel_e stat_sel;
    logic      twod;

    assign stat_sel = stat_sel_e'(acc_req_i.argb[1:0]);
    assign twod     = acc_req_i.argb[1];

    // -----------------------------------------------
    // opcode decode
    // -----------------------------------------------
    always_comb begin
        staged_d        = staged_q;
        acc_req_ready_o = 1'b0;
        rsp_valid_o     = 1'b0;
        push_o          = 1'b0;
        rsp_o.tag       = acc_req_i.tag;
        rsp_o.data      = '0;

        if (acc_req_valid_i) begin
            case (acc_req_i.op)
                OP_SRC: begin
                    staged_d.burst.src = acc_req_i.arga;
                    acc_req_ready_o    = 1'b1;
                end
                OP_DST: begin
                    staged_d.burst.dst = acc_req_i.arga;
                    acc_req_ready_o    = 1'b1;
                end
                OP_STR: begin
                    staged_d.src_stride = acc_req_i.arga;
                    staged_d.dst_stride = acc_req_i.argb;
                    acc_req_ready_o     = 1'b1;
                end
                OP_REP: begin
                    staged_d.reps   = acc_req_i.arga;
                    acc_req_ready_o = 1'b1;
                end
                OP_CPY: begin
                    // answer with the id this copy is about to take
                    rsp_o.data = next_id_i;
                    if (spill_ready_i && !fifo_full_i) begin
                        push_o          = 1'b1;
                        rsp_valid_o     = 1'b1;
                        acc_req_ready_o = 1'b1;
                    end
                end
                OP_STAT: begin
                    case (stat_sel)
                        STAT_COMPLETED: rsp_o.data = completed_id_i;
                        STAT_NEXT:      rsp_o.data = next_id_i;
                        STAT_BUSY:      rsp_o.data = {{(`DMA_FE_ID_W-1){1'b0}}, busy_i};
                        STAT_FULL:      rsp_o.data = {{(`DMA_FE_ID_W-1){1'b0}}, fifo_full_i};
                        default:        rsp_o.data = '0;
                    endcase
                    if (spill_ready_i) begin
                        rsp_valid_o     = 1'b1;
                        acc_req_ready_o = 1'b1;
                    end
                end
                // unknown opcodes stay unaccepted
                default: ;
            endcase
        end
    end

    // queued job, length from the copy itself
    always_comb begin
        job_o           = staged_q;
        job_o.burst.len = acc_req_i.arga;
        if (!twod || staged_q.reps == '0) begin
            job_o.reps = `DMA_FE_ADDR_W'(1);
        end
    end

    // staged job registers
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            staged_q <= '0;
        end else begin
            staged_q <= staged_d;
        end
    end

endmodule

//--- src/dma_fe_id_gen.sv
// -----------------------------------------------
// transfer id counters
// next id steps on issue, completed id on retire
// -----------------------------------------------

`include "dma_fe_consts.svh"

module dma_fe_id_gen (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    issue_i,
    input  logic                    retire_i,
    output logic [`DMA_FE_ID_W-1:0] next_id_o,
    output logic [`DMA_FE_ID_W-1:0] completed_id_o
);

    // id 0 means nothing completed yet
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            next_id_o      <= `DMA_FE_ID_W'(1);
            completed_id_o <= '0;
        end else begin
            if (issue_i) begin
                next_id_o <= next_id_o + 1'b1;
            end
            if (retire_i) begin
                completed_id_o <= completed_id_o + 1'b1;
            end
        end
    end

endmodule

//--- src/dma_fe_job_fifo.sv
// -----------------------------------------------
// job queue
// circular buffer of started jobs in front of the
// nd expander
// -----------------------------------------------

`include "dma_fe_consts.svh"

module dma_fe_job_fifo (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                push_i,
    input  dma_fe_pkg::nd_job_t job_i,
    output logic                full_o,
    input  logic                pop_i,
    output dma_fe_pkg::nd_job_t job_o,
    output logic                valid_o
);
    import dma_fe_pkg::*;

    localparam int unsigned Depth = `DMA_FE_FIFO_DEPTH;
    localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntW  = $clog2(Depth + 1);

    nd_job_t         mem_q [Depth];
    logic [PtrW-1:0] wr_ptr_q;
    logic [PtrW-1:0] rd_ptr_q;
    logic [CntW-1:0] count_q;
    logic            do_push;
    logic            do_pop;

    function automatic logic [PtrW-1:0] ptr_step(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CntW'(Depth));
    assign valid_o = (count_q != '0);
    assign job_o   = mem_q[rd_ptr_q];
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && valid_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_step(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_step(rd_ptr_q);
            end
            count_q <= count_q + CntW'(do_push) - CntW'(do_pop);
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= job_i;
        end
    end

endmodule

//--- src/dma_fe_nd_expand.sv
// -----------------------------------------------
// two-dimensional expander
// turns a job into one burst per row and retires
// it once every row has reported done
// -----------------------------------------------

`include "dma_fe_consts.svh"

module dma_fe_nd_expand (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  dma_fe_pkg::nd_job_t    job_i,
    input  logic                   job_valid_i,
    output logic                   pop_o,
    output dma_fe_pkg::burst_req_t burst_req_o,
    output logic                   burst_req_valid_o,
    input  logic                   burst_req_ready_i,
    input  logic                   burst_done_i,
    output logic                   retire_o,
    output logic                   busy_o
);
    import dma_fe_pkg::*;

    exp_state_e                state_q;
    exp_state_e                state_d;
    burst_req_t                row_q;
    logic [`DMA_FE_ADDR_W-1:0] src_stride_q;
    logic [`DMA_FE_ADDR_W-1:0] dst_stride_q;
    logic [`DMA_FE_ADDR_W-1:0] reps_q;
    logic [`DMA_FE_ADDR_W-1:0] issued_q;
    logic [`DMA_FE_ADDR_W-1:0] done_q;
    logic                      row_accept;
    logic                      row_last;
    logic                      done_last;

    assign row_accept = burst_req_valid_o && burst_req_ready_i;
    assign row_last   = (issued_q == reps_q - 1'b1);
    assign done_last  = (done_q == reps_q - 1'b1);

    assign pop_o             = (state_q == EXP_IDLE) && job_valid_i;
    assign burst_req_o       = row_q;
    assign burst_req_valid_o = (state_q == EXP_ISSUE);
    assign retire_o          = (state_q == EXP_DRAIN) && burst_done_i && done_last;
    // queued jobs count as busy too
    assign busy_o            = (state_q != EXP_IDLE) || job_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            EXP_IDLE:  if (job_valid_i) state_d = EXP_ISSUE;
            EXP_ISSUE: if (row_accept && row_last) state_d = EXP_DRAIN;
            EXP_DRAIN: if (retire_o) state_d = EXP_IDLE;
            default:   state_d = EXP_IDLE;
        endcase
    end

    // -----------------------------------------------
    // state and row / done counters
    // -----------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= EXP_IDLE;
            issued_q <= '0;
            done_q   <= '0;
        end else begin
            state_q <= state_d;
            if (pop_o) begin
                issued_q <= '0;
                done_q   <= '0;
            end else begin
                if (row_accept) begin
                    issued_q <= issued_q + 1'b1;
                end
                // dones for early rows may come while still issuing
                if (burst_done_i) begin
                    done_q <= done_q + 1'b1;
                end
            end
        end
    end

    // address accumulators, step by stride per row
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            row_q        <= job_i.burst;
            src_stride_q <= job_i.src_stride;
            dst_stride_q <= job_i.dst_stride;
            reps_q       <= job_i.reps;
        end else if (row_accept) begin
            row_q.src <= row_q.src + src_stride_q;
            row_q.dst <= row_q.dst + dst_stride_q;
        end
    end

endmodule

//--- src/dma_fe_pkg.sv
// -----------------------------------------------
// dma frontend types
// opcodes, states and the packed request, response
// and job records shared by the frontend blocks
// -----------------------------------------------

`include "dma_fe_consts.svh"

package dma_fe_pkg;

    typedef enum logic [2:0] {
        OP_SRC  = 3'd0,
        OP_DST  = 3'd1,
        OP_STR  = 3'd2,
        OP_REP  = 3'd3,
        OP_CPY  = 3'd4,
        OP_STAT = 3'd5
    } dma_op_e;

    // selector carried in argb[1:0] of a status read
    typedef enum logic [1:0] {
        STAT_COMPLETED = 2'd0,
        STAT_NEXT      = 2'd1,
        STAT_BUSY      = 2'd2,
        STAT_FULL      = 2'd3
    } stat_sel_e;

    typedef enum logic [1:0] {
        EXP_IDLE  = 2'd0,
        EXP_ISSUE = 2'd1,
        EXP_DRAIN = 2'd2
    } exp_state_e;

    typedef struct packed {
        logic [`DMA_FE_TAG_W-1:0]  tag;
        dma_op_e                   op;
        logic [`DMA_FE_ADDR_W-1:0] arga;
        logic [`DMA_FE_ADDR_W-1:0] argb;
    } acc_req_t;

    typedef struct packed {
        logic [`DMA_FE_TAG_W-1:0] tag;
        logic [`DMA_FE_ID_W-1:0]  data;
    } acc_rsp_t;

    typedef struct packed {
        logic [`DMA_FE_ADDR_W-1:0] src;
        logic [`DMA_FE_ADDR_W-1:0] dst;
        logic [`DMA_FE_ADDR_W-1:0] len;
    } burst_req_t;

    // one row request plus the second dimension
    typedef struct packed {
        burst_req_t                burst;
        logic [`DMA_FE_ADDR_W-1:0] src_stride;
        logic [`DMA_FE_ADDR_W-1:0] dst_stride;
        logic [`DMA_FE_ADDR_W-1:0] reps;
    } nd_job_t;

endpackage

//--- src/dma_fe_rsp_spill.sv
// -----------------------------------------------
// response spill buffer
// two slots, registered ready, keeps order
// -----------------------------------------------

module dma_fe_rsp_spill (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  dma_fe_pkg::acc_rsp_t rsp_i,
    input  logic                 valid_i,
    output logic                 ready_o,
    output dma_fe_pkg::acc_rsp_t rsp_o,
    output logic                 valid_o,
    input  logic                 ready_i
);
    import dma_fe_pkg::*;

    acc_rsp_t a_data_q;
    acc_rsp_t b_data_q;
    logic     a_full_q;
    logic     b_full_q;
    logic     a_fill;
    logic     a_drain;
    logic     b_fill;
    logic     b_drain;

    // slot b holds the older entry whenever it is full
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    assign rsp_o   = b_full_q ? b_data_q : a_data_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            a_full_q <= 1'b0;
            b_full_q <= 1'b0;
        end else begin
            if (a_fill) begin
                a_full_q <= 1'b1;
            end else if (a_drain) begin
                a_full_q <= 1'b0;
            end
            if (b_fill) begin
                b_full_q <= 1'b1;
            end else if (b_drain) begin
                b_full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (a_fill) begin
            a_data_q <= rsp_i;
        end
        if (b_fill) begin
            b_data_q <= a_data_q;
        end
    end

endmodule

//--- src/dma_fe_top.sv
// -----------------------------------------------
// tightly coupled dma frontend
// accelerator port in, row bursts out
// -----------------------------------------------

`include "dma_fe_consts.svh"

module dma_fe_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  dma_fe_pkg::acc_req_t   acc_req_i,
    input  logic                   acc_req_valid_i,
    output logic                   acc_req_ready_o,
    output dma_fe_pkg::acc_rsp_t   acc_rsp_o,
    output logic                   acc_rsp_valid_o,
    input  logic                   acc_rsp_ready_i,
    output dma_fe_pkg::burst_req_t burst_req_o,
    output logic                   burst_req_valid_o,
    input  logic                   burst_req_ready_i,
    input  logic                   burst_done_i,
    output logic                   busy_o
);
    import dma_fe_pkg::*;

    // decoder to spill buffer
    acc_rsp_t rsp;
    logic     rsp_valid;
    logic     spill_ready;

    // job queue
    nd_job_t  push_job;
    nd_job_t  pop_job;
    logic     push;
    logic     pop;
    logic     fifo_full;
    logic     fifo_valid;

    // transfer ids
    logic                    retire;
    logic [`DMA_FE_ID_W-1:0] next_id;
    logic [`DMA_FE_ID_W-1:0] completed_id;

    // -----------------------------------------------
    // decode and response path
    // -----------------------------------------------
    dma_fe_decode i_decode (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .acc_req_i       ( acc_req_i       ),
        .acc_req_valid_i ( acc_req_valid_i ),
        .acc_req_ready_o ( acc_req_ready_o ),
        .spill_ready_i   ( spill_ready     ),
        .rsp_o           ( rsp             ),
        .rsp_valid_o     ( rsp_valid       ),
        .fifo_full_i     ( fifo_full       ),
        .push_o          ( push            ),
        .job_o           ( push_job        ),
        .next_id_i       ( next_id         ),
        .completed_id_i  ( completed_id    ),
        .busy_i          ( busy_o          )
    );

    dma_fe_rsp_spill i_rsp_spill (
        .clk_i   ( clk_i           ),
        .rst_n_i ( rst_n_i         ),
        .rsp_i   ( rsp             ),
        .valid_i ( rsp_valid       ),
        .ready_o ( spill_ready     ),
        .rsp_o   ( acc_rsp_o       ),
        .valid_o ( acc_rsp_valid_o ),
        .ready_i ( acc_rsp_ready_i )
    );

    // a push is the issue of a new id
    dma_fe_id_gen i_id_gen (
        .clk_i          ( clk_i        ),
        .rst_n_i        ( rst_n_i      ),
        .issue_i        ( push         ),
        .retire_i       ( retire       ),
        .next_id_o      ( next_id      ),
        .completed_id_o ( completed_id )
    );

    // -----------------------------------------------
    // job queue and burst expansion
    // -----------------------------------------------
    dma_fe_job_fifo i_job_fifo (
        .clk_i   ( clk_i      ),
        .rst_n_i ( rst_n_i    ),
        .push_i  ( push       ),
        .job_i   ( push_job   ),
        .full_o  ( fifo_full  ),
        .pop_i   ( pop        ),
        .job_o   ( pop_job    ),
        .valid_o ( fifo_valid )
    );

    dma_fe_nd_expand i_nd_expand (
        .clk_i             ( clk_i             ),
        .rst_n_i           ( rst_n_i           ),
        .job_i             ( pop_job           ),
        .job_valid_i       ( fifo_valid        ),
        .pop_o             ( pop               ),
        .burst_req_o       ( burst_req_o       ),
        .burst_req_valid_o ( burst_req_valid_o ),
        .burst_req_ready_i ( burst_req_ready_i ),
        .burst_done_i      ( burst_done_i      ),
        .retire_o          ( retire            ),
        .busy_o            ( busy_o            )
    );

endmodule
